/* logic/core_pkg.sv */
`default_nettype none

package core_pkg;

	// Register values and memory addresses share one word
	localparam int DATA_W = 64;

	localparam int PRF_TAG_W = 6;	// 64 physical registers
	localparam int ROB_IDX_W = 6;	// Index plus wrap bit
	localparam int INST_W    = 32;	// Raw instruction word

endpackage

`default_nettype wire

/* logic/sq_pkg.sv */
`default_nettype none

package sq_pkg;

	localparam int OP_TYPE_W = 6;	// Memory operation type field

	// Queue geometry
	localparam int SQ_SIZE  = 8;
	localparam int SQ_PTR_W = $clog2(SQ_SIZE);	// Head and tail width

	// Store displacement inside the instruction word
	localparam int DISP_LSB = 0;
	localparam int DISP_W   = 16;	// Sign-extended to DATA_W

endpackage

`default_nettype wire

/* logic/sq_operand_slot.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_operand_slot (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           load,
	input  logic [core_pkg::DATA_W-1:0]    load_value,
	input  logic                           load_valid,
	input  logic                           cdb1_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb1_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb1_value,
	input  logic                           cdb2_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb2_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb2_value,
	output logic [core_pkg::DATA_W-1:0]    value,
	output logic                           ready
);

	logic [core_pkg::DATA_W-1:0]    cur_value;
	logic                           cur_ready;
	logic [core_pkg::PRF_TAG_W-1:0] cur_tag;
	logic                           hit1;
	logic                           hit2;

	// A slot being loaded snoops the buses against the incoming tag
	assign cur_value = load ? load_value : value;
	assign cur_ready = load ? load_valid : ready;
	assign cur_tag   = cur_value[core_pkg::PRF_TAG_W-1:0];	// Tag sits in the low bits

	assign hit1 = !cur_ready && cdb1_valid && (cdb1_tag == cur_tag);
	assign hit2 = !cur_ready && cdb2_valid && (cdb2_tag == cur_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			ready <= 1'b0;
		end else begin
			ready <= cur_ready || hit1 || hit2;
		end
	end

	always_ff @(posedge clock) begin
		if (hit2) begin
			value <= cdb2_value;	// CDB 2 wins a double match
		end else if (hit1) begin
			value <= cdb1_value;
		end else begin
			value <= cur_value;
		end
	end

endmodule

`default_nettype wire

/* logic/sq_one_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_one_entry (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           clear,
	input  logic                           alloc,
	input  logic [sq_pkg::OP_TYPE_W-1:0]   op_type,
	input  logic [core_pkg::INST_W-1:0]    inst,
	input  logic [core_pkg::ROB_IDX_W-1:0] rob_idx,
	input  logic [core_pkg::DATA_W-1:0]    base,
	input  logic                           base_valid,
	input  logic [core_pkg::DATA_W-1:0]    data,
	input  logic                           data_valid,
	input  logic                           cdb1_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb1_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb1_value,
	input  logic                           cdb2_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb2_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb2_value,
	output logic                           busy,
	output logic                           complete,
	output logic [core_pkg::INST_W-1:0]    entry_inst,
	output logic [core_pkg::DATA_W-1:0]    entry_base,
	output logic [core_pkg::DATA_W-1:0]    entry_data,
	output logic [core_pkg::ROB_IDX_W-1:0] entry_rob_idx,
	output logic [sq_pkg::OP_TYPE_W-1:0]   entry_op_type
);

	logic load;
	logic base_ready;
	logic data_ready;

	assign load = alloc && !clear;	// Clear beats alloc

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			busy <= 1'b0;
		end else if (alloc) begin
			busy <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			entry_inst    <= inst;
			entry_rob_idx <= rob_idx;
			entry_op_type <= op_type;
		end
	end

	// Base address operand
	sq_operand_slot u_base (
		.clock, .reset, .load,
		.load_value (base),
		.load_valid (base_valid),
		.cdb1_valid, .cdb1_tag, .cdb1_value,
		.cdb2_valid, .cdb2_tag, .cdb2_value,
		.value      (entry_base),
		.ready      (base_ready)
	);

	// Store data operand
	sq_operand_slot u_data (
		.clock, .reset, .load,
		.load_value (data),
		.load_valid (data_valid),
		.cdb1_valid, .cdb1_tag, .cdb1_value,
		.cdb2_valid, .cdb2_tag, .cdb2_value,
		.value      (entry_data),
		.ready      (data_ready)
	);

	assign complete = busy && base_ready && data_ready;

endmodule

`default_nettype wire

/* logic/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           flush,
	input  logic                           disp_valid1,
	input  logic [sq_pkg::OP_TYPE_W-1:0]   op_type1,
	input  logic [core_pkg::INST_W-1:0]    inst1,
	input  logic [core_pkg::ROB_IDX_W-1:0] rob_idx1,
	input  logic [core_pkg::DATA_W-1:0]    base1,
	input  logic                           base_valid1,
	input  logic [core_pkg::DATA_W-1:0]    data1,
	input  logic                           data_valid1,
	input  logic                           disp_valid2,
	input  logic [sq_pkg::OP_TYPE_W-1:0]   op_type2,
	input  logic [core_pkg::INST_W-1:0]    inst2,
	input  logic [core_pkg::ROB_IDX_W-1:0] rob_idx2,
	input  logic [core_pkg::DATA_W-1:0]    base2,
	input  logic                           base_valid2,
	input  logic [core_pkg::DATA_W-1:0]    data2,
	input  logic                           data_valid2,
	output logic                           disp_ready,
	input  logic                           cdb1_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb1_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb1_value,
	input  logic                           cdb2_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb2_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb2_value,
	output logic                           issue_valid,
	output logic [core_pkg::DATA_W-1:0]    issue_addr,
	output logic [core_pkg::DATA_W-1:0]    issue_data,
	input  logic                           issue_ready
);

	logic [sq_pkg::SQ_PTR_W-1:0] head;
	logic [sq_pkg::SQ_PTR_W-1:0] tail;
	logic [sq_pkg::SQ_PTR_W-1:0] lane2_slot;
	logic [sq_pkg::SQ_PTR_W:0]   count;
	logic [sq_pkg::SQ_PTR_W:0]   count_next;
	logic [1:0]                  n_alloc;
	logic                        acc1;
	logic                        acc2;
	logic                        issue_fire;
	logic [sq_pkg::SQ_SIZE-1:0]  complete;
	logic [core_pkg::INST_W-1:0] entry_inst [sq_pkg::SQ_SIZE];
	logic [core_pkg::DATA_W-1:0] entry_base [sq_pkg::SQ_SIZE];
	logic [core_pkg::DATA_W-1:0] entry_data [sq_pkg::SQ_SIZE];
	logic [sq_pkg::DISP_W-1:0]   head_disp;

	assign acc1       = disp_valid1 && disp_ready && !flush;
	assign acc2       = disp_valid2 && disp_ready && !flush;
	assign n_alloc    = {1'b0, acc1} + {1'b0, acc2};
	assign lane2_slot = acc1 ? tail + 1'b1 : tail;	// Lane 2 follows lane 1
	assign issue_fire = issue_valid && issue_ready;
	assign count_next = count + (sq_pkg::SQ_PTR_W + 1)'(n_alloc)
		- (sq_pkg::SQ_PTR_W + 1)'(issue_fire);

	always_ff @(posedge clock) begin
		if (reset) begin
			head       <= '0;
			tail       <= '0;
			count      <= '0;
			disp_ready <= 1'b0;
		end else if (flush) begin
			head       <= '0;
			tail       <= '0;
			count      <= '0;
			disp_ready <= 1'b1;	// Queue is empty again
		end else begin
			head       <= head + sq_pkg::SQ_PTR_W'(issue_fire);
			tail       <= tail + sq_pkg::SQ_PTR_W'(n_alloc);
			count      <= count_next;
			// Both lanes must fit before dispatch is offered
			disp_ready <= (int'(count_next) <= sq_pkg::SQ_SIZE - 2);
		end
	end

	for (genvar i = 0; i < sq_pkg::SQ_SIZE; i++) begin : g_entry
		logic alloc1_here;
		logic alloc2_here;
		logic retire_here;

		assign alloc1_here = acc1 && (int'(tail) == i);
		assign alloc2_here = acc2 && (int'(lane2_slot) == i);
		assign retire_here = issue_fire && (int'(head) == i);

		sq_one_entry u_entry (
			.clock, .reset,
			.clear         (flush || retire_here),
			.alloc         (alloc1_here || alloc2_here),
			.op_type       (alloc2_here ? op_type2 : op_type1),
			.inst          (alloc2_here ? inst2 : inst1),
			.rob_idx       (alloc2_here ? rob_idx2 : rob_idx1),
			.base          (alloc2_here ? base2 : base1),
			.base_valid    (alloc2_here ? base_valid2 : base_valid1),
			.data          (alloc2_here ? data2 : data1),
			.data_valid    (alloc2_here ? data_valid2 : data_valid1),
			.cdb1_valid, .cdb1_tag, .cdb1_value,
			.cdb2_valid, .cdb2_tag, .cdb2_value,
			.busy          (),
			.complete      (complete[i]),
			.entry_inst    (entry_inst[i]),
			.entry_base    (entry_base[i]),
			.entry_data    (entry_data[i]),
			.entry_rob_idx (),
			.entry_op_type ()
		);
	end

	// Oldest store only, so writes leave in program order
	assign head_disp   = entry_inst[head][sq_pkg::DISP_LSB +: sq_pkg::DISP_W];
	assign issue_valid = complete[head];
	assign issue_addr  = entry_base[head]
		+ {{(core_pkg::DATA_W - sq_pkg::DISP_W){head_disp[sq_pkg::DISP_W-1]}}, head_disp};
	assign issue_data  = entry_data[head];

endmodule

`default_nettype wire

/* logic/sq_mem_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_mem_issue (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        flush,
	input  logic                        issue_valid,
	input  logic [core_pkg::DATA_W-1:0] issue_addr,
	input  logic [core_pkg::DATA_W-1:0] issue_data,
	output logic                        issue_ready,
	output logic                        mem_valid,
	output logic [core_pkg::DATA_W-1:0] mem_addr,
	output logic [core_pkg::DATA_W-1:0] mem_data,
	input  logic                        mem_ready
);

	assign issue_ready = !mem_valid || mem_ready;	// Empty or draining this cycle

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			mem_valid <= 1'b0;	// Unaccepted write is dropped
		end else if (issue_ready) begin
			mem_valid <= issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue_ready && issue_valid) begin
			mem_addr <= issue_addr;
			mem_data <= issue_data;
		end
	end

endmodule

`default_nettype wire

/* logic/sq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_top (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           flush,
	input  logic                           disp_valid1,
	input  logic [sq_pkg::OP_TYPE_W-1:0]   op_type1,
	input  logic [core_pkg::INST_W-1:0]    inst1,
	input  logic [core_pkg::ROB_IDX_W-1:0] rob_idx1,
	input  logic [core_pkg::DATA_W-1:0]    base1,
	input  logic                           base_valid1,
	input  logic [core_pkg::DATA_W-1:0]    data1,
	input  logic                           data_valid1,
	input  logic                           disp_valid2,
	input  logic [sq_pkg::OP_TYPE_W-1:0]   op_type2,
	input  logic [core_pkg::INST_W-1:0]    inst2,
	input  logic [core_pkg::ROB_IDX_W-1:0] rob_idx2,
	input  logic [core_pkg::DATA_W-1:0]    base2,
	input  logic                           base_valid2,
	input  logic [core_pkg::DATA_W-1:0]    data2,
	input  logic                           data_valid2,
	output logic                           disp_ready,
	input  logic                           cdb1_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb1_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb1_value,
	input  logic                           cdb2_valid,
	input  logic [core_pkg::PRF_TAG_W-1:0] cdb2_tag,
	input  logic [core_pkg::DATA_W-1:0]    cdb2_value,
	output logic                           mem_valid,
	output logic [core_pkg::DATA_W-1:0]    mem_addr,
	output logic [core_pkg::DATA_W-1:0]    mem_data,
	input  logic                           mem_ready
);

	// Queue head to output register
	logic                        issue_valid;
	logic [core_pkg::DATA_W-1:0] issue_addr;
	logic [core_pkg::DATA_W-1:0] issue_data;
	logic                        issue_ready;

	store_queue u_store_queue (
		.*
	);

	sq_mem_issue u_mem_issue (
		.*
	);

endmodule

`default_nettype wire

/* verif/store_queue_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue_sva (
	input logic                          clock,
	input logic                          reset,
	input logic                          flush,
	input logic [sq_pkg::SQ_PTR_W:0]     count,
	input logic                          disp_ready,
	input logic                          issue_valid,
	input logic                          out_valid,
	input logic [core_pkg::DATA_W-1:0]   out_addr,
	input logic [core_pkg::DATA_W-1:0]   out_data,
	input logic                          out_ready
);

	int fail_count = 0;	// Failed properties so far

	occupancy_bound: assert property (@(posedge clock) disable iff (reset)
		int'(count) <= sq_pkg::SQ_SIZE) else begin
		$error("Queue occupancy above depth");
		fail_count++;
	end

	out_stable: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !flush |=> out_valid && $stable(out_addr) && $stable(out_data))
		else begin
		$error("Write request changed under back-pressure");
		fail_count++;
	end

	ready_needs_room: assert property (@(posedge clock) disable iff (reset)
		(sq_pkg::SQ_SIZE - int'(count) < 2) |-> !disp_ready) else begin
		$error("Dispatch offered with fewer than two free entries");
		fail_count++;
	end

	no_issue_empty: assert property (@(posedge clock) disable iff (reset)
		count == '0 |-> !issue_valid) else begin
		$error("Issue from an empty queue");
		fail_count++;
	end

endmodule

bind store_queue store_queue_sva u_queue_sva (
	.clock, .reset, .flush, .count, .disp_ready, .issue_valid,
	.out_valid (1'b0), .out_addr ('0), .out_data ('0), .out_ready (1'b1)
);

bind sq_mem_issue store_queue_sva u_issue_sva (
	.clock, .reset, .flush, .count ('0), .disp_ready (1'b1), .issue_valid (1'b0),
	.out_valid (mem_valid), .out_addr (mem_addr), .out_data (mem_data), .out_ready (mem_ready)
);

`default_nettype wire

/* verif/sq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_tb;

	localparam int GOLDEN_DEPTH = 64;
	localparam int CMD_W        = 152;	// Kind, flags, displacement, base, data

	logic                           clock;
	logic                           reset;
	logic                           flush;
	logic                           disp_valid1;
	logic [sq_pkg::OP_TYPE_W-1:0]   op_type1;
	logic [core_pkg::INST_W-1:0]    inst1;
	logic [core_pkg::ROB_IDX_W-1:0] rob_idx1;
	logic [core_pkg::DATA_W-1:0]    base1;
	logic                           base_valid1;
	logic [core_pkg::DATA_W-1:0]    data1;
	logic                           data_valid1;
	logic                           disp_valid2;
	logic [sq_pkg::OP_TYPE_W-1:0]   op_type2;
	logic [core_pkg::INST_W-1:0]    inst2;
	logic [core_pkg::ROB_IDX_W-1:0] rob_idx2;
	logic [core_pkg::DATA_W-1:0]    base2;
	logic                           base_valid2;
	logic [core_pkg::DATA_W-1:0]    data2;
	logic                           data_valid2;
	logic                           disp_ready;
	logic                           cdb1_valid;
	logic [core_pkg::PRF_TAG_W-1:0] cdb1_tag;
	logic [core_pkg::DATA_W-1:0]    cdb1_value;
	logic                           cdb2_valid;
	logic [core_pkg::PRF_TAG_W-1:0] cdb2_tag;
	logic [core_pkg::DATA_W-1:0]    cdb2_value;
	logic                           mem_valid;
	logic [core_pkg::DATA_W-1:0]    mem_addr;
	logic [core_pkg::DATA_W-1:0]    mem_data;
	logic                           mem_ready;

	logic [CMD_W-1:0]   golden [GOLDEN_DEPTH];
	logic [127:0]       exp_q [$];	// Expected {addr, data} in program order
	logic [CMD_W-1:0]   cmd;
	logic [1:0]         ready_mode;	// 0 high, 1 random, 2 held low
	logic [1023:0]      ready_bits;	// One random mem_ready bit per cycle
	logic               draining;
	logic               dispatching;
	int                 idx;
	int                 n_lines;
	int                 expect_total;
	int                 expects_seen;
	int                 writes_done;
	int                 cycles;
	int                 timeout_limit;

	sq_top uut (.*);

	always #10 clock = ~clock;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// Drive one golden command; dispatch and CDB fields go out on this edge
	task automatic apply_command(input logic [CMD_W-1:0] c);
		case (c[151:148])
			4'h1: begin
				disp_valid1 <= 1'b1;
				inst1       <= {16'h0, c[143:128]};
				base1       <= c[127:64];
				base_valid1 <= c[144];
				data1       <= c[63:0];
				data_valid1 <= c[145];
				dispatching = 1'b1;
			end
			4'h2: begin
				disp_valid2 <= 1'b1;
				inst2       <= {16'h0, c[143:128]};
				base2       <= c[127:64];
				base_valid2 <= c[144];
				data2       <= c[63:0];
				data_valid2 <= c[145];
				dispatching = 1'b1;
			end
			4'h4: begin
				cdb1_valid <= c[144];
				cdb1_tag   <= c[133:128];
				cdb1_value <= c[127:64];
				cdb2_valid <= c[145];
				cdb2_tag   <= c[141:136];
				cdb2_value <= c[63:0];
			end
			4'h5: flush <= 1'b1;
			4'h6: ready_mode <= c[145:144];
			4'h7: draining <= 1'b1;
			4'h8: expects_seen++;
			default: fail_run("Unknown command kind in golden file");
		endcase
	endtask

	always @(posedge clock) begin
		if (draining) begin
			mem_ready <= 1'b1;	// Drain runs at full speed
		end else if (ready_mode == 2'd1) begin
			mem_ready <= ready_bits[cycles % 1024];
		end else begin
			mem_ready <= (ready_mode == 2'd0);
		end
	end

	// Memory model compares each accepted write with the next record
	always @(posedge clock) begin
		logic [127:0] exp;
		if (!reset && mem_valid && mem_ready) begin
			assert (exp_q.size() != 0) else
				fail_run($sformatf("Memory write at %0t with no store left to expect", $time));
			exp = exp_q.pop_front();
			assert (mem_addr == exp[127:64]) else
				fail_run($sformatf("Mismatch at %0t: mem_addr got %h expected %h",
					$time, mem_addr, exp[127:64]));
			assert (mem_data == exp[63:0]) else
				fail_run($sformatf("Mismatch at %0t: mem_data got %h expected %h",
					$time, mem_data, exp[63:0]));
			writes_done <= writes_done + 1;
		end
	end

	// Bound assertions count their failures
	always @(posedge clock) begin
		assert (uut.u_store_queue.u_queue_sva.fail_count == 0
			&& uut.u_mem_issue.u_issue_sva.fail_count == 0) else
			fail_run("A bound assertion on the queue or the output register failed");
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit)
			fail_run("Timeout: the expected memory writes did not all arrive");
	end

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		flush        = 1'b0;
		mem_ready    = 1'b0;
		disp_valid1  = 1'b0;
		op_type1     = '0;
		inst1        = '0;
		rob_idx1     = '0;
		base1        = '0;
		base_valid1  = 1'b0;
		data1        = '0;
		data_valid1  = 1'b0;
		disp_valid2  = 1'b0;
		op_type2     = '0;
		inst2        = '0;
		rob_idx2     = '0;
		base2        = '0;
		base_valid2  = 1'b0;
		data2        = '0;
		data_valid2  = 1'b0;
		cdb1_valid   = 1'b0;
		cdb1_tag     = '0;
		cdb1_value   = '0;
		cdb2_valid   = 1'b0;
		cdb2_tag     = '0;
		cdb2_value   = '0;
		ready_mode   = 2'd0;
		draining     = 1'b0;
		dispatching  = 1'b0;
		expects_seen = 0;
		writes_done  = 0;
		cycles       = 0;
		n_lines      = 0;
		expect_total = 0;
		void'($urandom(32'hc21dd819));
		for (int i = 0; i < 32; i++)
			ready_bits[i*32 +: 32] = $urandom;
		foreach (golden[i]) golden[i] = '0;	// Kind 0 ends the run
		$readmemh("verif/sq_golden.mem", golden);
		while (n_lines < GOLDEN_DEPTH && golden[n_lines][151:148] != 4'h0) begin
			if (golden[n_lines][151:148] == 4'h8) begin
				exp_q.push_back(golden[n_lines][127:0]);
				expect_total++;
			end
			n_lines++;
		end
		timeout_limit = n_lines * 20 + 200;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		idx = 0;
		while (idx < n_lines) begin
			disp_valid1 <= 1'b0;
			disp_valid2 <= 1'b0;
			cdb1_valid  <= 1'b0;
			cdb2_valid  <= 1'b0;
			flush       <= 1'b0;
			dispatching = 1'b0;
			draining    <= 1'b0;
			do begin
				cmd = golden[idx];
				idx++;
				apply_command(cmd);
			end while (cmd[146] && idx < n_lines);	// Flag bit 2 merges with the next line
			do @(posedge clock); while (dispatching && !disp_ready);
			while (draining && writes_done < expects_seen) @(posedge clock);
		end
		draining <= 1'b1;
		repeat (20) @(posedge clock);
		if (writes_done == expect_total && exp_q.size() == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("Run ended with %0d of %0d writes seen", writes_done, expect_total);
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* verif/sq_golden.mem */
// kind flags disp base data; kind 1/2 lane, 4 cdb, 5 flush, 6 ready mode, 7 drain, 8 expect
// flags bit0 base valid or cdb1, bit1 data valid or cdb2, bit2 same cycle as next line
1_3_0010_0000000000001000_1111111111111111
8_0_0000_0000000000001010_1111111111111111
2_3_8000_0000000000010000_5555555555555555
8_0_0000_0000000000008000_5555555555555555
1_0_0000_0000000000000005_0000000000000006
4_3_0605_0000000000006000_6666666666666666
8_0_0000_0000000000006000_6666666666666666
1_6_0002_0000000000000007_7777777777777777
4_2_0700_0000000000000000_0000000000007000
8_0_0000_0000000000007002_7777777777777777
7_0_0000_0000000000000000_0000000000000000
6_2_0000_0000000000000000_0000000000000000
1_7_0004_000000000000A000_A1A1A1A1A1A1A1A1
2_3_FFFC_000000000000A100_A2A2A2A2A2A2A2A2
1_7_0004_000000000000B000_B1B1B1B1B1B1B1B1
2_3_FFFC_000000000000B100_B2B2B2B2B2B2B2B2
1_7_0004_000000000000C000_C1C1C1C1C1C1C1C1
2_3_FFFC_000000000000C100_C2C2C2C2C2C2C2C2
1_7_0004_000000000000D000_D1D1D1D1D1D1D1D1
2_3_FFFC_000000000000D100_D2D2D2D2D2D2D2D2
6_1_0000_0000000000000000_0000000000000000
8_0_0000_000000000000A004_A1A1A1A1A1A1A1A1
8_0_0000_000000000000A0FC_A2A2A2A2A2A2A2A2
8_0_0000_000000000000B004_B1B1B1B1B1B1B1B1
8_0_0000_000000000000B0FC_B2B2B2B2B2B2B2B2
8_0_0000_000000000000C004_C1C1C1C1C1C1C1C1
8_0_0000_000000000000C0FC_C2C2C2C2C2C2C2C2
8_0_0000_000000000000D004_D1D1D1D1D1D1D1D1
8_0_0000_000000000000D0FC_D2D2D2D2D2D2D2D2
7_0_0000_0000000000000000_0000000000000000
6_0_0000_0000000000000000_0000000000000000
1_4_0000_0000000000000010_0000000000000011
2_0_0000_0000000000000012_0000000000000013
5_0_0000_0000000000000000_0000000000000000
4_3_1110_000000000000E000_EEEEEEEEEEEEEEEE
1_3_0001_000000000000F000_FFFFFFFFFFFFFFFF
8_0_0000_000000000000F001_FFFFFFFFFFFFFFFF
7_0_0000_0000000000000000_0000000000000000

/* verilog.f */
logic/core_pkg.sv
logic/sq_pkg.sv
logic/sq_operand_slot.sv
logic/sq_one_entry.sv
logic/store_queue.sv
logic/sq_mem_issue.sv
logic/sq_top.sv
verif/store_queue_sva.sv
verif/sq_tb.sv

/* Bender.yml */
package:
  name: store_queue

sources:
  - logic/core_pkg.sv
  - logic/sq_pkg.sv
  - logic/sq_operand_slot.sv
  - logic/sq_one_entry.sv
  - logic/store_queue.sv
  - logic/sq_mem_issue.sv
  - logic/sq_top.sv
  - target: simulation
    files:
      - verif/store_queue_sva.sv
      - verif/sq_tb.sv
